// ==== exec_pkg.sv ====
package exec_pkg;

    // Micro-operations issued by decode
    typedef enum logic [4:0] {
        ADD,
        AND,
        OR,
        NOT,
        SAL,
        SAR,
        MOV,
        CMOVC,
        XCHG,
        MOVS,
        PUSH,
        POP,
        CALL,
        RET,
        JMP,
        JCC,
        CLD,
        STD
    } p_op_e;

    typedef enum logic [1:0] {
        SZ8,
        SZ16,
        SZ32
    } op_size_e;

    // Conditions for JCC, only CF and ZF are tested
    typedef enum logic [1:0] {
        C_C,
        C_NC,
        C_Z,
        C_NZ
    } cond_e;

    localparam int FLAGS_W = 12;

    // x86 bit positions in EFLAGS
    localparam int FL_CF = 0;
    localparam int FL_PF = 2;
    localparam int FL_AF = 4;
    localparam int FL_ZF = 6;
    localparam int FL_SF = 7;
    localparam int FL_DF = 10;
    localparam int FL_OF = 11;

    localparam int unsigned STACK_STEP = 4; // Stack ops always 32-bit

endpackage

// ==== exec_alu.sv ====
`timescale 1ns/10ps

module exec_alu (
    input  exec_pkg::p_op_e              p_op,
    input  exec_pkg::op_size_e           size,
    input  logic [31:0]                  op1,
    input  logic [31:0]                  op2,
    input  logic [exec_pkg::FLAGS_W-1:0] flags_in,
    output logic [31:0]                  result,
    output logic [exec_pkg::FLAGS_W-1:0] flags_new,
    output logic [exec_pkg::FLAGS_W-1:0] flags_mask
);
    import exec_pkg::*;

    localparam logic [FLAGS_W-1:0] ARITH_MASK = FLAGS_W'((1 << FL_CF) | (1 << FL_PF) |
        (1 << FL_AF) | (1 << FL_ZF) | (1 << FL_SF) | (1 << FL_OF));
    // AF left alone by shifts
    localparam logic [FLAGS_W-1:0] SHIFT_MASK = FLAGS_W'((1 << FL_CF) | (1 << FL_PF) |
        (1 << FL_ZF) | (1 << FL_SF) | (1 << FL_OF));

    logic [31:0] size_mask;
    logic [5:0]  width;         // 8, 16 or 32
    logic [4:0]  msb;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;          // a sign-extended from its top bit
    logic [4:0]  cnt;
    logic [32:0] sum;
    logic [63:0] sal_ext;
    logic [64:0] sar_ext;       // Bit 0 catches the last bit out
    logic [31:0] r;
    logic        carry;
    logic        ovf;
    logic        aux;

    always_comb begin
        case (size)
            SZ8: begin
                size_mask = 32'h0000_00ff;
                width     = 6'd8;
            end
            SZ16: begin
                size_mask = 32'h0000_ffff;
                width     = 6'd16;
            end
            default: begin
                size_mask = 32'hffff_ffff;
                width     = 6'd32;
            end
        endcase
    end

    assign msb  = 5'(width - 6'd1);
    assign a    = op1 & size_mask;
    assign b    = op2 & size_mask;
    assign sext = a[msb] ? (a | ~size_mask) : a;
    assign cnt  = op2[4:0];

    assign sum     = {1'b0, a} + {1'b0, b};
    assign sal_ext = {32'd0, a} << cnt;
    assign sar_ext = $signed({{32{sext[31]}}, sext, 1'b0}) >>> cnt;

    always_comb begin
        r     = a;
        carry = 1'b0;
        case (p_op)
            ADD: begin
                r     = sum[31:0] & size_mask;
                carry = sum[width];
            end
            AND: r = a & b;
            OR:  r = a | b;
            NOT: r = ~op1 & size_mask;
            SAL: begin
                r     = sal_ext[31:0] & size_mask;
                carry = sal_ext[width];
            end
            SAR: begin
                r     = sar_ext[32:1] & size_mask;
                carry = sar_ext[0];
            end
            default: ;
        endcase
    end

    // Only ADD produces overflow and adjust
    assign ovf = (p_op == ADD) && (a[msb] == b[msb]) && (r[msb] != a[msb]);
    assign aux = (p_op == ADD) && ((a[4] ^ b[4]) ^ r[4]);

    always_comb begin
        result     = op1;
        flags_new  = flags_in;
        flags_mask = '0;
        flags_new[FL_CF] = carry;
        flags_new[FL_PF] = ~^r[7:0];     // Even parity, low byte
        flags_new[FL_AF] = aux;
        flags_new[FL_ZF] = (r == 32'd0);
        flags_new[FL_SF] = r[msb];
        flags_new[FL_OF] = ovf;
        case (p_op)
            ADD, AND, OR: begin
                result     = r;
                flags_mask = ARITH_MASK;
            end
            NOT: result = r;
            SAL, SAR: begin
                result = r;
                if (cnt != 5'd0) begin
                    flags_mask = SHIFT_MASK;
                end
            end
            MOV, CMOVC, XCHG: result = op2; // Moves keep full width
            default: ;
        endcase
    end

endmodule

// ==== exec_ptr_update.sv ====
`timescale 1ns/10ps

module exec_ptr_update (
    input  exec_pkg::p_op_e    p_op,
    input  exec_pkg::op_size_e size,
    input  logic               df,
    input  logic [31:0]        op1,
    input  logic [31:0]        op2,
    input  logic [31:0]        op3,
    input  logic [31:0]        op4,
    output logic [31:0]        res2,
    output logic [31:0]        res3,
    output logic [31:0]        res4
);
    import exec_pkg::*;

    logic [31:0] movs_step;
    logic [31:0] stack_adj;
    logic        is_movs;

    assign is_movs = (p_op == MOVS);

    // String step by element size, backward when DF set
    always_comb begin
        case (size)
            SZ8:     movs_step = 32'd1;
            SZ16:    movs_step = 32'd2;
            default: movs_step = 32'd4;
        endcase
        if (df) begin
            movs_step = -movs_step;
        end
    end

    always_comb begin
        case (p_op)
            PUSH, CALL: stack_adj = -32'(STACK_STEP);
            POP:        stack_adj = 32'(STACK_STEP);
            RET:        stack_adj = 32'(STACK_STEP) + {16'd0, op2[15:0]}; // RET imm16
            default:    stack_adj = 32'd0;
        endcase
    end

    always_comb begin
        res2 = op2;
        if (is_movs) begin
            res2 = op2 + movs_step;     // Source index
        end else if (p_op == XCHG) begin
            res2 = op1;
        end
    end

    assign res3 = is_movs ? op3 + movs_step : op3; // Destination index
    assign res4 = op4 + stack_adj;                 // ESP, zero adjust passes through

endmodule

// ==== exec_eflags.sv ====
`timescale 1ns/10ps

module exec_eflags (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         load,
    input  exec_pkg::p_op_e              p_op,
    input  logic [exec_pkg::FLAGS_W-1:0] flags_new,
    input  logic [exec_pkg::FLAGS_W-1:0] flags_mask,
    output logic [exec_pkg::FLAGS_W-1:0] flags_q
);
    import exec_pkg::*;

    // Bits that exist, everything else reads 0
    localparam logic [FLAGS_W-1:0] DEFINED = FLAGS_W'((1 << FL_CF) | (1 << FL_PF) |
        (1 << FL_AF) | (1 << FL_ZF) | (1 << FL_SF) | (1 << FL_DF) | (1 << FL_OF));

    logic [FLAGS_W-1:0] flags_d;

    always_comb begin
        flags_d = (flags_q & ~flags_mask) | (flags_new & flags_mask);
        if (p_op == STD) begin
            flags_d[FL_DF] = 1'b1;
        end else if (p_op == CLD) begin
            flags_d[FL_DF] = 1'b0;
        end
        flags_d = flags_d & DEFINED;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags_q <= '0;
        end else if (load) begin
            flags_q <= flags_d;     // Committed on accept only
        end
    end

endmodule

// ==== exec_branch.sv ====
`timescale 1ns/10ps

module exec_branch (
    input  exec_pkg::p_op_e              p_op,
    input  exec_pkg::cond_e              cond,
    input  logic [exec_pkg::FLAGS_W-1:0] flags_q,
    input  logic [31:0]                  op1,
    input  logic [31:0]                  eip,
    input  logic                         pred_taken,
    input  logic [31:0]                  pred_target,
    output logic                         cond_true,
    output logic                         br_valid,
    output logic                         br_taken,
    output logic                         br_correct,
    output logic [31:0]                  br_target
);
    import exec_pkg::*;

    logic cc_hold;
    logic taken;

    always_comb begin
        case (cond)
            C_C:     cc_hold = flags_q[FL_CF];
            C_NC:    cc_hold = ~flags_q[FL_CF];
            C_Z:     cc_hold = flags_q[FL_ZF];
            default: cc_hold = ~flags_q[FL_ZF];
        endcase
    end

    always_comb begin
        case (p_op)
            CMOVC:   cond_true = flags_q[FL_CF]; // Move on carry
            JCC:     cond_true = cc_hold;
            default: cond_true = 1'b0;
        endcase
    end

    assign br_valid = (p_op == CALL) || (p_op == RET) || (p_op == JMP) || (p_op == JCC);

    // Unconditional transfers always go, JCC on its condition
    assign taken     = br_valid && ((p_op != JCC) || cond_true);
    assign br_taken  = taken;
    assign br_target = taken ? op1 : eip;

    // Direction must match, target only matters when taken
    assign br_correct = br_valid && (taken == pred_taken) &&
                        (!taken || (op1 == pred_target));

endmodule

// ==== exec_top.sv ====
`timescale 1ns/10ps

module exec_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  exec_pkg::p_op_e              p_op,
    input  exec_pkg::op_size_e           size,
    input  exec_pkg::cond_e              cond,
    input  logic [31:0]                  op1,
    input  logic [31:0]                  op2,
    input  logic [31:0]                  op3,
    input  logic [31:0]                  op4,
    input  logic [31:0]                  eip,
    input  logic                         pred_taken,
    input  logic [31:0]                  pred_target,
    input  logic                         out_ready,
    output logic                         out_valid,
    output logic [31:0]                  res1,
    output logic                         res1_wb,
    output logic [31:0]                  res2,
    output logic [31:0]                  res3,
    output logic [31:0]                  res4,
    output logic [exec_pkg::FLAGS_W-1:0] eflags,
    output logic                         br_valid,
    output logic                         br_taken,
    output logic                         br_correct,
    output logic [31:0]                  br_target
);
    import exec_pkg::*;

    logic               accept;
    logic [FLAGS_W-1:0] flags_q;
    logic [FLAGS_W-1:0] flags_new;
    logic [FLAGS_W-1:0] flags_mask;
    logic [31:0]        alu_res;
    logic [31:0]        res1_d;
    logic [31:0]        res2_d;
    logic [31:0]        res3_d;
    logic [31:0]        res4_d;
    logic               res1_wb_d;
    logic               cond_true;
    logic               br_valid_d;
    logic               br_taken_d;
    logic               br_correct_d;
    logic [31:0]        br_target_d;

    assign in_ready = !out_valid || out_ready; // Single-entry output register
    assign accept   = in_valid && in_ready;

    exec_alu alu_i (
        .p_op       (p_op),
        .size       (size),
        .op1        (op1),
        .op2        (op2),
        .flags_in   (flags_q),
        .result     (alu_res),
        .flags_new  (flags_new),
        .flags_mask (flags_mask)
    );

    exec_ptr_update ptr_i (
        .p_op (p_op),
        .size (size),
        .df   (flags_q[FL_DF]),
        .op1  (op1),
        .op2  (op2),
        .op3  (op3),
        .op4  (op4),
        .res2 (res2_d),
        .res3 (res3_d),
        .res4 (res4_d)
    );

    exec_eflags eflags_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .load       (accept),
        .p_op       (p_op),
        .flags_new  (flags_new),
        .flags_mask (flags_mask),
        .flags_q    (flags_q)
    );

    exec_branch branch_i (
        .p_op        (p_op),
        .cond        (cond),
        .flags_q     (flags_q),
        .op1         (op1),
        .eip         (eip),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .cond_true   (cond_true),
        .br_valid    (br_valid_d),
        .br_taken    (br_taken_d),
        .br_correct  (br_correct_d),
        .br_target   (br_target_d)
    );

    assign res1_d = (p_op == CALL) ? eip : alu_res; // Return address

    always_comb begin
        case (p_op)
            JMP, JCC, RET, CLD, STD: res1_wb_d = 1'b0;
            CMOVC:                   res1_wb_d = cond_true;
            default:                 res1_wb_d = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            res1_wb    <= 1'b0;
            br_valid   <= 1'b0;
            br_taken   <= 1'b0;
            br_correct <= 1'b0;
        end else begin
            if (accept) begin
                out_valid  <= 1'b1;
                res1_wb    <= res1_wb_d;
                br_valid   <= br_valid_d;
                br_taken   <= br_taken_d;
                br_correct <= br_correct_d;
            end else if (out_ready) begin
                out_valid <= 1'b0;  // Consumed, nothing new
            end
        end
    end

    // Data words, held while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            res1      <= res1_d;
            res2      <= res2_d;
            res3      <= res3_d;
            res4      <= res4_d;
            br_target <= br_target_d;
        end
    end

    assign eflags = flags_q;

endmodule

// ==== tb_exec_chk.sv ====
`timescale 1ns/10ps

module tb_exec_chk (
    input logic                         clk,
    input logic                         arst_n,
    input logic                         in_ready,
    input logic                         out_valid,
    input logic                         out_ready,
    input logic [31:0]                  res1,
    input logic                         res1_wb,
    input logic [31:0]                  res2,
    input logic [31:0]                  res3,
    input logic [31:0]                  res4,
    input logic [exec_pkg::FLAGS_W-1:0] eflags,
    input logic                         br_valid,
    input logic                         br_taken,
    input logic                         br_correct,
    input logic [31:0]                  br_target
);

    // Output register empty while in reset
    idle_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // Stalled item must not move
    hold_when_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(res1) && $stable(res1_wb) &&
            $stable(res2) && $stable(res3) && $stable(res4) && $stable(eflags) &&
            $stable(br_valid) && $stable(br_taken) && $stable(br_correct) &&
            $stable(br_target))
        else $error("Outputs changed while stalled");

    ready_rule: assert property (@(posedge clk) disable iff (!arst_n)
        in_ready == (!out_valid || out_ready))
        else $error("in_ready does not follow the output register state");

    branch_flags: assert property (@(posedge clk) disable iff (!arst_n)
        (br_taken || br_correct) |-> br_valid)
        else $error("Branch taken or correct without br_valid");

endmodule

// ==== tb_exec.sv ====
`timescale 1ns/10ps

module tb_exec;
    import exec_pkg::*;

    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 4 + 100;

    typedef struct packed {
        logic [31:0]        res1;
        logic               res1_wb;
        logic [31:0]        res2;
        logic [31:0]        res3;
        logic [31:0]        res4;
        logic [FLAGS_W-1:0] flags;
        logic               br_valid;
        logic               br_taken;
        logic               br_correct;
        logic [31:0]        br_target;
    } exp_t;

    logic               clk;
    logic               arst_n;
    logic               in_valid;
    logic               in_ready;
    p_op_e              p_op;
    op_size_e           size;
    cond_e              cond;
    logic [31:0]        op1;
    logic [31:0]        op2;
    logic [31:0]        op3;
    logic [31:0]        op4;
    logic [31:0]        eip;
    logic               pred_taken;
    logic [31:0]        pred_target;
    logic               out_ready;
    logic               out_valid;
    logic [31:0]        res1;
    logic               res1_wb;
    logic [31:0]        res2;
    logic [31:0]        res3;
    logic [31:0]        res4;
    logic [FLAGS_W-1:0] eflags;
    logic               br_valid;
    logic               br_taken;
    logic               br_correct;
    logic [31:0]        br_target;

    exp_t               exp_q[$];
    exp_t               next_exp;
    exp_t               cur;
    logic [FLAGS_W-1:0] model_flags;
    logic               took_last;     // Offer accepted at the last rising edge
    int                 n_offered;
    int                 n_accepted;
    int                 n_checked;
    int                 n_errors;
    int                 n_cycles;

    exec_top exec_top_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .p_op        (p_op),
        .size        (size),
        .cond        (cond),
        .op1         (op1),
        .op2         (op2),
        .op3         (op3),
        .op4         (op4),
        .eip         (eip),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .res1        (res1),
        .res1_wb     (res1_wb),
        .res2        (res2),
        .res3        (res3),
        .res4        (res4),
        .eflags      (eflags),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_correct  (br_correct),
        .br_target   (br_target)
    );

    bind exec_top tb_exec_chk chk_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .res1       (res1),
        .res1_wb    (res1_wb),
        .res2       (res2),
        .res3       (res3),
        .res4       (res4),
        .eflags     (eflags),
        .br_valid   (br_valid),
        .br_taken   (br_taken),
        .br_correct (br_correct),
        .br_target  (br_target)
    );

    // ZF, SF and PF of a sized result
    function automatic logic [FLAGS_W-1:0] set_zsp_flags(input logic [FLAGS_W-1:0] fl,
                                                          input logic [31:0] r, input int w);
        logic [FLAGS_W-1:0] f;

        f = fl;
        f[FL_ZF] = (r == 32'd0);
        f[FL_SF] = r[w-1];
        f[FL_PF] = ~^r[7:0];
        return f;
    endfunction

    function automatic exp_t exec_ref(
        input p_op_e              op,
        input op_size_e           sz,
        input cond_e              cc,
        input logic [31:0]        o1,
        input logic [31:0]        o2,
        input logic [31:0]        o3,
        input logic [31:0]        o4,
        input logic [31:0]        ip,
        input logic               ptaken,
        input logic [31:0]        ptarget,
        input logic [FLAGS_W-1:0] fl
    );
        exp_t        e;
        int          w;
        int          n;
        int          i;
        logic [31:0] m;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [32:0] wide;
        logic [4:0]  nib;
        logic [31:0] step;
        longint      sa;
        longint      sb;
        longint      ssum;
        logic        cf;
        logic        sign;
        logic        taken;

        w = (sz == SZ8) ? 8 : ((sz == SZ16) ? 16 : 32);
        m = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
        a = o1 & m;
        b = o2 & m;
        n = int'(o2[4:0]);
        taken = 1'b0;
        e.res1 = o1;
        e.res1_wb = 1'b1;
        e.res2 = o2;
        e.res3 = o3;
        e.res4 = o4;
        e.flags = fl;
        e.br_valid = 1'b0;
        e.br_taken = 1'b0;
        e.br_correct = 1'b0;
        e.br_target = ip;

        case (op)
            ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                r = wide[31:0] & m;
                nib = {1'b0, a[3:0]} + {1'b0, b[3:0]};    // Carry out of bit 3
                // Operands as signed numbers of the operand width
                sa = a[w-1] ? longint'(a) - (longint'(1) << w) : longint'(a);
                sb = b[w-1] ? longint'(b) - (longint'(1) << w) : longint'(b);
                ssum = sa + sb;
                e.res1 = r;
                e.flags[FL_CF] = wide[w];
                e.flags[FL_OF] = (ssum >= (longint'(1) << (w - 1))) ||
                                 (ssum < -(longint'(1) << (w - 1)));   // Out of signed range
                e.flags[FL_AF] = nib[4];
                e.flags = set_zsp_flags(e.flags, r, w);
            end
            AND, OR: begin
                r = (op == AND) ? (a & b) : (a | b);
                e.res1 = r;
                e.flags[FL_CF] = 1'b0;
                e.flags[FL_OF] = 1'b0;
                e.flags[FL_AF] = 1'b0;
                e.flags = set_zsp_flags(e.flags, r, w);
            end
            NOT: e.res1 = ~o1 & m;
            SAL, SAR: begin
                r = a;
                cf = 1'b0;
                sign = a[w-1];
                // One bit at a time, CF keeps the last bit out
                for (i = 0; i < n; i++) begin
                    if (op == SAL) begin
                        cf = r[w-1];
                        r = (r << 1) & m;
                    end else begin
                        cf = r[0];
                        r = (r >> 1) | ({31'd0, sign} << (w - 1));
                    end
                end
                e.res1 = r;
                if (n != 0) begin
                    e.flags[FL_CF] = cf;
                    e.flags[FL_OF] = 1'b0;
                    e.flags = set_zsp_flags(e.flags, r, w);
                end
            end
            MOV: e.res1 = o2;
            CMOVC: begin
                e.res1 = o2;
                e.res1_wb = fl[FL_CF];
            end
            XCHG: begin
                e.res1 = o2;
                e.res2 = o1;
            end
            MOVS: begin
                step = (w == 8) ? 32'd1 : ((w == 16) ? 32'd2 : 32'd4);
                if (fl[FL_DF]) begin
                    step = -step;
                end
                e.res2 = o2 + step;
                e.res3 = o3 + step;
            end
            PUSH: e.res4 = o4 - 32'd4;
            POP:  e.res4 = o4 + 32'd4;
            CALL: begin
                e.res1 = ip;
                e.res4 = o4 - 32'd4;
                taken = 1'b1;
            end
            RET: begin
                e.res4 = o4 + 32'd4 + {16'd0, o2[15:0]};
                e.res1_wb = 1'b0;
                taken = 1'b1;
            end
            JMP: begin
                e.res1_wb = 1'b0;
                taken = 1'b1;
            end
            JCC: begin
                e.res1_wb = 1'b0;
                case (cc)
                    C_C:     taken = fl[FL_CF];
                    C_NC:    taken = !fl[FL_CF];
                    C_Z:     taken = fl[FL_ZF];
                    default: taken = !fl[FL_ZF];
                endcase
            end
            CLD: begin
                e.flags[FL_DF] = 1'b0;
                e.res1_wb = 1'b0;
            end
            STD: begin
                e.flags[FL_DF] = 1'b1;
                e.res1_wb = 1'b0;
            end
            default: ;
        endcase

        e.br_valid = (op == CALL) || (op == RET) || (op == JMP) || (op == JCC);
        if (e.br_valid) begin
            e.br_taken = taken;
            e.br_target = taken ? o1 : ip;
            e.br_correct = (taken == ptaken) && (!taken || (o1 == ptarget));
        end
        return e;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("ERROR %0t: %s got %h expected %h", $time, name, got, want);
            n_errors++;
        end
    endtask

    task automatic random_uop();
        p_op = p_op_e'(5'($urandom_range(17, 0)));
        size = op_size_e'(2'($urandom_range(2, 0)));
        cond = cond_e'(2'($urandom_range(3, 0)));
        op1 = $urandom;
        if ($urandom_range(7, 0) == 0) begin
            op1 = 32'd0;
        end
        op2 = $urandom;
        case ($urandom_range(7, 0))
            0: op2 = -op1;                  // ADD wraps to zero with carry
            1: op2[4:0] = 5'd0;             // Zero-count shift
            default: ;
        endcase
        op3 = $urandom;
        op4 = $urandom;
        eip = $urandom;
        pred_taken = 1'($urandom_range(1, 0));
        // Half the predictions name the real target
        pred_target = ($urandom_range(1, 0) == 1) ? op1 : $urandom;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        n_cycles = 0;
        while (n_cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n_cycles++;
        end
        $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // Reference model on every acceptance
    always @(posedge clk) begin
        if (arst_n && in_valid && in_ready) begin
            next_exp = exec_ref(p_op, size, cond, op1, op2, op3, op4, eip,
                                pred_taken, pred_target, model_flags);
            model_flags = next_exp.flags;
            exp_q.push_back(next_exp);
            n_accepted++;
            took_last = 1'b1;
        end else begin
            took_last = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (arst_n && out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("ERROR %0t: out_valid high with no accepted micro-op", $time);
                n_errors++;
            end
            if (out_ready && exp_q.size() != 0) begin
                cur = exp_q.pop_front();
                check_field("res1", res1, cur.res1);
                check_field("res1_wb", 32'(res1_wb), 32'(cur.res1_wb));
                check_field("res2", res2, cur.res2);
                check_field("res3", res3, cur.res3);
                check_field("res4", res4, cur.res4);
                check_field("eflags", 32'(eflags), 32'(cur.flags));
                check_field("br_valid", 32'(br_valid), 32'(cur.br_valid));
                check_field("br_taken", 32'(br_taken), 32'(cur.br_taken));
                check_field("br_correct", 32'(br_correct), 32'(cur.br_correct));
                check_field("br_target", br_target, cur.br_target);
                n_checked++;
            end
        end
    end

    initial begin
        arst_n = 1'b0;
        in_valid = 1'b0;
        p_op = ADD;
        size = SZ32;
        cond = C_C;
        op1 = 32'd0;
        op2 = 32'd0;
        op3 = 32'd0;
        op4 = 32'd0;
        eip = 32'd0;
        pred_taken = 1'b0;
        pred_target = 32'd0;
        out_ready = 1'b0;
        model_flags = '0;
        took_last = 1'b0;
        n_offered = 0;
        n_accepted = 0;
        n_checked = 0;
        n_errors = 0;
        void'($urandom(32'h315b));

        repeat (4) begin
            @(negedge clk);
            check_field("out_valid", 32'(out_valid), 32'd0);
            check_field("eflags", 32'(eflags), 32'd0);
        end
        arst_n = 1'b1;

        while (n_accepted < NUM_OPS) begin
            @(negedge clk);
            out_ready = ($urandom_range(3, 0) != 0);
            if (!in_valid || took_last) begin       // Offer is held until taken
                if (n_offered < NUM_OPS && $urandom_range(3, 0) != 0) begin
                    random_uop();
                    in_valid = 1'b1;
                    n_offered++;
                end else begin
                    in_valid = 1'b0;
                end
            end
        end

        // Drain the output register
        while (exp_q.size() != 0) begin
            @(negedge clk);
            in_valid = 1'b0;
            out_ready = 1'b1;
        end
        @(negedge clk);
        check_field("out_valid", 32'(out_valid), 32'd0);

        $display("Accepted %0d, checked %0d, errors %0d", n_accepted, n_checked, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
exec_pkg.sv
exec_alu.sv
exec_ptr_update.sv
exec_eflags.sv
exec_branch.sv
exec_top.sv
tb_exec_chk.sv
tb_exec.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exec -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_exec)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
